//--- hdl/core_pkg.sv
/*
 * Shared widths, control encodings and pipeline register layouts for the
 * five-stage integer core. Every RTL file refers to these by scoped name.
 */
package core_pkg;

    // Fixed by the ISA
    localparam int WORD_BITS    = 32;
    localparam int REG_COUNT    = 32;
    localparam int REG_IDX_BITS = $clog2(REG_COUNT);

    typedef logic [WORD_BITS-1:0]    word_t;
    typedef logic [REG_IDX_BITS-1:0] reg_idx_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_t;

    // Operand source for the EX stage
    typedef enum logic [1:0] {
        FWD_REGFILE, FWD_EX_MEM, FWD_MEM_WB
    } fwd_sel_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;
        alu_op_t alu_op;
    } ctrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    load_data;
    } mem_wb_t;

    typedef struct packed {
        reg_idx_t reg_idx;
        word_t    data;
    } report_t;

    // ADDI x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // Saved registers that are reported: s1 and s2..s9
    localparam reg_idx_t SAVED_REG_S1 = 5'd9;
    localparam reg_idx_t SAVED_REG_LO = 5'd18;
    localparam reg_idx_t SAVED_REG_HI = 5'd25;

endpackage

//--- hdl/data_memory.sv
/*
 * Word data RAM for the MEM stage. Stores commit on the clock edge and
 * loads read combinationally. Only the word index bits of address count.
 */
`timescale 1ns/1ps

module data_memory #(
    parameter int DMEM_INDEX_BITS = 8
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            load,
    input  logic            store,
    input  core_pkg::word_t address,
    input  core_pkg::word_t store_data,
    output core_pkg::word_t load_data
);

    localparam int DEPTH = 1 << DMEM_INDEX_BITS;

    core_pkg::word_t            mem [0:DEPTH-1];
    logic [DMEM_INDEX_BITS-1:0] index;

    // Skip the byte offset
    assign index = address[DMEM_INDEX_BITS+1:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (store) begin
            mem[index] <= store_data;
        end
    end

    assign load_data = load ? mem[index] : '0;

    one_access: assert property (@(posedge clock) disable iff (reset) !(load && store))
        else $error("load and store in the same cycle");

endmodule

//--- hdl/decode_unit.sv
/*
 * Instruction decoder for the ID stage. Purely combinational: splits the
 * IF/ID word into register indices, control and a sign-extended immediate.
 */
`timescale 1ns/1ps

module decode_unit (
    input  core_pkg::word_t    instr,
    output core_pkg::reg_idx_t rs1,
    output core_pkg::reg_idx_t rs2,
    output core_pkg::reg_idx_t rd,
    output core_pkg::ctrl_t    ctrl,
    output core_pkg::word_t    imm
);

    core_pkg::opcode_t opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    core_pkg::word_t   imm_i;
    core_pkg::word_t   imm_s;
    core_pkg::word_t   imm_u;

    assign opcode = core_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    // Shared funct3 table for OP and OP_IMM, alt picks SUB or SRA
    function automatic core_pkg::alu_op_t alu_from_funct3(input logic [2:0] f3,
                                                          input logic alt_sub,
                                                          input logic alt_sra);
        case (f3)
            3'b000:  return alt_sub ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  return core_pkg::ALU_SLL;
            3'b010:  return core_pkg::ALU_SLT;
            3'b011:  return core_pkg::ALU_SLTU;
            3'b100:  return core_pkg::ALU_XOR;
            3'b101:  return alt_sra ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  return core_pkg::ALU_OR;
            default: return core_pkg::ALU_AND;
        endcase
    endfunction

    // Unused source fields read as x0 so they never stall or forward
    always_comb begin
        ctrl = '0;
        imm  = '0;
        rs1  = '0;
        rs2  = '0;
        case (opcode)
            core_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct3(funct3, funct7[5], funct7[5]);
                rs1            = instr[19:15];
                rs2            = instr[24:20];
            end
            core_pkg::OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = alu_from_funct3(funct3, 1'b0, funct7[5]);
                imm            = imm_i;
                rs1            = instr[19:15];
            end
            core_pkg::OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = core_pkg::ALU_PASS_B;
                imm            = imm_u;
            end
            core_pkg::OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
                imm            = imm_i;
                rs1            = instr[19:15];
            end
            core_pkg::OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                imm            = imm_s;
                rs1            = instr[19:15];
                rs2            = instr[24:20];
            end
            // Anything else passes through as a no-op
            default: ;
        endcase
    end

endmodule

//--- hdl/execution_unit.sv
/*
 * EX stage datapath. Chooses operand B and runs the integer ALU.
 * Operand A and the rs2 value arrive already forwarded.
 */
`timescale 1ns/1ps

module execution_unit (
    input  core_pkg::ctrl_t ctrl,
    input  core_pkg::word_t operand_a,
    input  core_pkg::word_t rs2_value,
    input  core_pkg::word_t imm,
    output core_pkg::word_t alu_result
);

    core_pkg::word_t operand_b;
    logic [4:0]      shamt;

    assign operand_b = ctrl.use_imm ? imm : rs2_value;
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            core_pkg::ALU_ADD:    alu_result = operand_a + operand_b;
            core_pkg::ALU_SUB:    alu_result = operand_a - operand_b;
            core_pkg::ALU_AND:    alu_result = operand_a & operand_b;
            core_pkg::ALU_OR:     alu_result = operand_a | operand_b;
            core_pkg::ALU_XOR:    alu_result = operand_a ^ operand_b;
            core_pkg::ALU_SLT: begin
                alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            end
            core_pkg::ALU_SLTU: begin
                alu_result = {31'b0, operand_a < operand_b};
            end
            core_pkg::ALU_SLL:    alu_result = operand_a << shamt;
            core_pkg::ALU_SRL:    alu_result = operand_a >> shamt;
            core_pkg::ALU_SRA:    alu_result = $signed(operand_a) >>> shamt;
            // LUI carries its upper immediate straight through
            core_pkg::ALU_PASS_B: alu_result = operand_b;
            default:              alu_result = '0;
        endcase
    end

endmodule

//--- hdl/hazard_unit.sv
/*
 * Hazard logic. Detects the load-use case between ID and EX and selects
 * the forwarding source for both operands of the instruction in EX.
 */
`timescale 1ns/1ps

module hazard_unit (
    input  core_pkg::reg_idx_t ifid_rs1,
    input  core_pkg::reg_idx_t ifid_rs2,
    input  core_pkg::reg_idx_t idex_rd,
    input  logic               idex_mem_read,
    input  core_pkg::reg_idx_t idex_rs1,
    input  core_pkg::reg_idx_t idex_rs2,
    input  logic               exmem_reg_write,
    input  core_pkg::reg_idx_t exmem_rd,
    input  logic               memwb_reg_write,
    input  core_pkg::reg_idx_t memwb_rd,
    output logic               stall,
    output core_pkg::fwd_sel_t fwd_a,
    output core_pkg::fwd_sel_t fwd_b
);

    // Load result is not ready until MEM, so hold ID one cycle
    assign stall = idex_mem_read && (idex_rd != '0) &&
                   ((ifid_rs1 == idex_rd) || (ifid_rs2 == idex_rd));

    // Youngest producer wins
    function automatic core_pkg::fwd_sel_t pick_source(input core_pkg::reg_idx_t src);
        if (exmem_reg_write && (exmem_rd != '0) && (exmem_rd == src)) begin
            return core_pkg::FWD_EX_MEM;
        end
        if (memwb_reg_write && (memwb_rd != '0) && (memwb_rd == src)) begin
            return core_pkg::FWD_MEM_WB;
        end
        return core_pkg::FWD_REGFILE;
    endfunction

    always_comb begin
        fwd_a = pick_source(idex_rs1);
        fwd_b = pick_source(idex_rs2);
    end

    stall_only_on_load: assert final (!stall || idex_mem_read)
        else $error("stall raised without a load in EX");

endmodule

//--- hdl/register_file.sv
/*
 * Integer register file, x0 hard-wired to zero. Writes land on the clock
 * edge and a same-cycle read of the written register sees the new value.
 */
`timescale 1ns/1ps

module register_file (
    input  logic               clock,
    input  logic               reset,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data,
    input  logic               write,
    input  core_pkg::reg_idx_t write_reg,
    input  core_pkg::word_t    write_data
);

    core_pkg::word_t regs [1:core_pkg::REG_COUNT-1];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < core_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write && (write_reg != '0)) begin
            regs[write_reg] <= write_data;
        end
    end

    // Write-first bypass covers the WB to ID distance
    function automatic core_pkg::word_t read_port(input core_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (write && (write_reg == idx)) begin
            return write_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    x0_reads_zero: assert property (@(posedge clock) disable iff (reset)
        ((rs1 == '0) |-> (rs1_data == '0)) and ((rs2 == '0) |-> (rs2_data == '0)))
        else $error("x0 read returned nonzero data");

endmodule

//--- hdl/riscv_pipeline.sv
/*
 * Five-stage in-order integer core fed by a valid/ready instruction stream.
 * Holds the pipeline registers, forwarding muxes and writeback, and reports
 * every write to a saved register one cycle after it retires.
 */
`timescale 1ns/1ps

module riscv_pipeline #(
    parameter int DMEM_INDEX_BITS = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  core_pkg::word_t   instr,
    input  logic              instr_valid,
    output logic              instr_ready,
    output core_pkg::report_t report,
    output logic              report_valid
);

    // Pipeline registers
    core_pkg::word_t   if_id;
    core_pkg::id_ex_t  id_ex;
    core_pkg::ex_mem_t ex_mem;
    core_pkg::mem_wb_t mem_wb;

    logic               running;
    logic               stall;

    // ID stage
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::reg_idx_t rd;
    core_pkg::ctrl_t    ctrl;
    core_pkg::word_t    imm;
    core_pkg::word_t    rs1_data;
    core_pkg::word_t    rs2_data;

    // EX stage
    core_pkg::fwd_sel_t fwd_a;
    core_pkg::fwd_sel_t fwd_b;
    core_pkg::word_t    operand_a;
    core_pkg::word_t    rs2_value;
    core_pkg::word_t    alu_result;

    // MEM and WB
    core_pkg::word_t    load_data;
    core_pkg::word_t    wb_data;
    logic               rf_write;
    logic               saved_write;

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID and the input handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign instr_ready = running && !stall;

    // Idle input turns into a bubble and a stall holds the word in ID
    always_ff @(posedge clock) begin
        if (reset) begin
            if_id <= core_pkg::NOP_INSTR;
        end else if (!stall) begin
            if_id <= (instr_valid && instr_ready) ? instr : core_pkg::NOP_INSTR;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ID stage
    ////////////////////////////////////////////////////////////////////////////

    decode_unit decode0 (
        .instr (if_id),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    register_file regfile0 (
        .clock      (clock),
        .reset      (reset),
        .rs1        (rs1),
        .rs2        (rs2),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .write      (rf_write),
        .write_reg  (mem_wb.rd),
        .write_data (wb_data)
    );

    hazard_unit hazard0 (
        .ifid_rs1        (rs1),
        .ifid_rs2        (rs2),
        .idex_rd         (id_ex.rd),
        .idex_mem_read   (id_ex.ctrl.mem_read),
        .idex_rs1        (id_ex.rs1),
        .idex_rs2        (id_ex.rs2),
        .exmem_reg_write (ex_mem.reg_write),
        .exmem_rd        (ex_mem.rd),
        .memwb_reg_write (mem_wb.reg_write),
        .memwb_rd        (mem_wb.rd),
        .stall           (stall),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b)
    );

    // A stall sends a bubble into EX by clearing control only
    always_ff @(posedge clock) begin
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rd       <= rd;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
        if (reset || stall) begin
            id_ex.ctrl <= '0;
        end else begin
            id_ex.ctrl <= ctrl;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // EX stage
    ////////////////////////////////////////////////////////////////////////////

    function automatic core_pkg::word_t pick_operand(input core_pkg::fwd_sel_t sel,
                                                     input core_pkg::word_t reg_value);
        case (sel)
            core_pkg::FWD_EX_MEM: return ex_mem.alu_result;
            core_pkg::FWD_MEM_WB: return wb_data;
            default:              return reg_value;
        endcase
    endfunction

    always_comb begin
        operand_a = pick_operand(fwd_a, id_ex.rs1_data);
        rs2_value = pick_operand(fwd_b, id_ex.rs2_data);
    end

    execution_unit exec0 (
        .ctrl       (id_ex.ctrl),
        .operand_a  (operand_a),
        .rs2_value  (rs2_value),
        .imm        (id_ex.imm),
        .alu_result (alu_result)
    );

    always_ff @(posedge clock) begin
        ex_mem.rd         <= id_ex.rd;
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= rs2_value;
        if (reset) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem.reg_write <= id_ex.ctrl.reg_write;
            ex_mem.mem_read  <= id_ex.ctrl.mem_read;
            ex_mem.mem_write <= id_ex.ctrl.mem_write;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // MEM and WB stages
    ////////////////////////////////////////////////////////////////////////////

    data_memory #(
        .DMEM_INDEX_BITS (DMEM_INDEX_BITS)
    ) dmem0 (
        .clock      (clock),
        .reset      (reset),
        .load       (ex_mem.mem_read),
        .store      (ex_mem.mem_write),
        .address    (ex_mem.alu_result),
        .store_data (ex_mem.store_data),
        .load_data  (load_data)
    );

    always_ff @(posedge clock) begin
        mem_wb.rd         <= ex_mem.rd;
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.load_data  <= load_data;
        if (reset) begin
            mem_wb.reg_write <= 1'b0;
            mem_wb.mem_read  <= 1'b0;
        end else begin
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.mem_read  <= ex_mem.mem_read;
        end
    end

    assign wb_data  = mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_result;
    assign rf_write = mem_wb.reg_write && (mem_wb.rd != '0);

    // s1 and s2..s9 hold the results the consumer watches
    assign saved_write = rf_write &&
                         ((mem_wb.rd == core_pkg::SAVED_REG_S1) ||
                          ((mem_wb.rd >= core_pkg::SAVED_REG_LO) &&
                           (mem_wb.rd <= core_pkg::SAVED_REG_HI)));

    always_ff @(posedge clock) begin
        if (reset) begin
            report_valid <= 1'b0;
        end else begin
            report_valid <= saved_write;
        end
        if (saved_write) begin
            report.reg_idx <= mem_wb.rd;
            report.data    <= wb_data;
        end
    end

    report_saved_only: assert property (@(posedge clock) disable iff (reset)
        report_valid |-> ((report.reg_idx == core_pkg::SAVED_REG_S1) ||
                          ((report.reg_idx >= core_pkg::SAVED_REG_LO) &&
                           (report.reg_idx <= core_pkg::SAVED_REG_HI))))
        else $error("report names a register outside the saved set");

endmodule

//--- list.f
+incdir+verif
hdl/core_pkg.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/hazard_unit.sv
hdl/execution_unit.sv
hdl/data_memory.sv
hdl/riscv_pipeline.sv
verif/tb_riscv_pipeline.sv

//--- verif/core_model.svh
/*
 * Reference model and random instruction source for the core testbench.
 * Included inside the testbench module. Runs each accepted instruction on
 * an architectural register file and memory and queues expected reports.
 */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

core_pkg::word_t   ref_regs [0:31];
core_pkg::word_t   ref_mem [0:(1 << DMEM_BITS)-1];
core_pkg::report_t expected_reports [$];
int                reports_expected = 0;

// Mostly x0, s1 and s2..s9, with x5 and x6 as unreported targets
function automatic core_pkg::reg_idx_t pick_reg();
    int unsigned r;
    r = $urandom_range(0, 11);
    if (r == 0) return 5'd0;
    if (r == 1) return 5'd9;
    if (r <= 9) return core_pkg::reg_idx_t'(r + 16);
    return core_pkg::reg_idx_t'(r - 5);
endfunction

function automatic core_pkg::word_t gen_instr();
    int unsigned        kind;
    int unsigned        op;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    logic [2:0]         f3;
    logic [11:0]        imm12;
    logic [11:0]        offset;
    logic [19:0]        upper;
    kind   = $urandom_range(0, 9);
    op     = $urandom_range(0, 9);
    rd     = pick_reg();
    rs1    = pick_reg();
    rs2    = pick_reg();
    imm12  = 12'($urandom_range(0, 4095));
    upper  = 20'($urandom());
    f3     = (op == 8) ? 3'b000 : (op == 9) ? 3'b101 : op[2:0];
    // R-type, op 8 is SUB and op 9 is SRA
    if (kind <= 2) return {((op >= 8) ? 7'h20 : 7'h00), rs2, rs1, f3, rd, 7'b0110011};
    if (kind <= 5) begin
        // Shift immediates carry only a shamt, op 9 is SRAI
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm12 = {((op == 9) ? 7'h20 : 7'h00), imm12[4:0]};
        end
        return {imm12, rs1, f3, rd, 7'b0010011};
    end
    if (kind == 6) return {upper, rd, 7'b0110111};
    // Loads reach words 0..15, stores only 0..11
    if (kind <= 8) begin
        offset = {6'b0, 4'($urandom_range(0, 15)), 2'b00};
        return {offset, 5'd0, 3'b010, rd, 7'b0000011};
    end
    offset = {6'b0, 4'($urandom_range(0, 11)), 2'b00};
    return {offset[11:5], rs2, 5'd0, 3'b010, offset[4:0], 7'b0100011};
endfunction

function automatic core_pkg::word_t expected_alu(input logic [2:0] f3, input logic alt_sub,
                                                 input logic alt_sra, input core_pkg::word_t a,
                                                 input core_pkg::word_t b);
    case (f3)
        3'b000:  return alt_sub ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt_sra) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// Source registers by ISA format, LUI reads none
function automatic logic reads_register(input core_pkg::word_t w, input core_pkg::reg_idx_t r);
    case (w[6:0])
        7'b0110011, 7'b0100011: return (w[19:15] == r) || (w[24:20] == r);
        7'b0010011, 7'b0000011: return w[19:15] == r;
        default:                return 1'b0;
    endcase
endfunction

function automatic void execute_instr(input core_pkg::word_t w);
    core_pkg::reg_idx_t   rd;
    core_pkg::word_t      a;
    core_pkg::word_t      b;
    core_pkg::word_t      imm_i;
    core_pkg::word_t      addr;
    core_pkg::word_t      result;
    logic                 writes;
    core_pkg::report_t    rep;
    rd     = w[11:7];
    a      = ref_regs[w[19:15]];
    b      = ref_regs[w[24:20]];
    imm_i  = {{20{w[31]}}, w[31:20]};
    writes = 1'b1;
    result = '0;
    case (w[6:0])
        7'b0110011: result = expected_alu(w[14:12], w[30], w[30], a, b);
        7'b0010011: result = expected_alu(w[14:12], 1'b0, w[30], a, imm_i);
        7'b0110111: result = {w[31:12], 12'h000};
        7'b0000011: begin
            addr   = a + imm_i;
            result = ref_mem[addr[DMEM_BITS+1:2]];
        end
        7'b0100011: begin
            addr   = a + {{20{w[31]}}, w[31:25], w[11:7]};
            ref_mem[addr[DMEM_BITS+1:2]] = b;
            writes = 1'b0;
        end
        default: writes = 1'b0;
    endcase
    if (writes && rd != 5'd0) begin
        ref_regs[rd] = result;
        // s1 and s2..s9 are the watched registers
        if (rd == 5'd9 || (rd >= 5'd18 && rd <= 5'd25)) begin
            rep.reg_idx = rd;
            rep.data    = result;
            expected_reports.push_back(rep);
            reports_expected++;
        end
    end
endfunction

`endif

//--- verif/tb_riscv_pipeline.sv
/*
 * Testbench for the five-stage core. Streams seeded random instructions
 * with idle gaps, checks saved-register reports against the reference
 * model in order and checks the length of every load-use stall.
 */
`timescale 1ns/1ps

module tb_riscv_pipeline;

    localparam int DMEM_BITS = 8;
    localparam int NUM_INSTR = 400;
    localparam int MAX_IDLE  = 3;
    // Worst case per instruction is an idle gap, one stall and the accept
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (MAX_IDLE + 2) + 60;

    logic              clock;
    logic              reset;
    core_pkg::word_t   instr;
    logic              instr_valid;
    logic              instr_ready;
    core_pkg::report_t report;
    logic              report_valid;

    int report_errors = 0;
    int stall_errors  = 0;
    int other_errors  = 0;
    int reports_seen  = 0;
    int stalls_seen   = 0;
    int cycle_count   = 0;

    // Load-use tracking for the most recently accepted instruction
    logic               stall_pending    = 1'b0;
    int                 stall_expected   = 0;
    int                 stall_low_cycles = 0;
    core_pkg::reg_idx_t last_load_rd     = '0;

    `include "core_model.svh"

    riscv_pipeline #(
        .DMEM_INDEX_BITS (DMEM_BITS)
    ) dut0 (
        .clock        (clock),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .report       (report),
        .report_valid (report_valid)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_report(input core_pkg::report_t got, input core_pkg::report_t exp);
        if (got !== exp) begin
            report_errors++;
            $display("FAILED report: reg_idx got 0x%h expected 0x%h, data got 0x%h expected 0x%h",
                     got.reg_idx, exp.reg_idx, got.data, exp.data);
        end
    endtask

    task automatic check_stall(input int got, input int exp);
        if (got != exp) begin
            stall_errors++;
            $display("FAILED instr_ready low cycles: got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            other_errors++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("Summary: %0d report errors, %0d stall errors, %0d other errors (%0d reports, %0d stalls)",
                 report_errors, stall_errors, other_errors, reports_seen, stalls_seen);
    endtask

    // One cycle, observed at the falling edge where outputs are settled
    task automatic step();
        @(negedge clock);
        if (report_valid === 1'b1) begin
            reports_seen++;
            if (expected_reports.size() == 0) begin
                other_errors++;
                $display("A report for x%0d arrived that the model did not expect",
                         report.reg_idx);
            end else begin
                check_report(report, expected_reports.pop_front());
            end
        end
        if (stall_pending) begin
            if (!instr_ready) begin
                stall_low_cycles++;
            end else begin
                check_stall(stall_low_cycles, stall_expected);
                if (stall_low_cycles > 0) stalls_seen++;
                stall_pending = 1'b0;
            end
        end
    endtask

    task automatic accept_instr(input core_pkg::word_t word);
        stall_expected   = (last_load_rd != '0 && reads_register(word, last_load_rd)) ? 1 : 0;
        stall_pending    = 1'b1;
        stall_low_cycles = 0;
        last_load_rd     = (word[6:0] == 7'b0000011) ? word[11:7] : 5'd0;
        execute_instr(word);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        core_pkg::word_t next_instr;
        logic            have_next;
        int              sent;
        int              idle_left;
        void'($urandom(11));
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = core_pkg::NOP_INSTR;
        have_next   = 1'b0;
        sent        = 0;
        idle_left   = 0;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        for (int i = 0; i < (1 << DMEM_BITS); i++) ref_mem[i] = '0;

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_flag("report_valid", report_valid, 1'b0);
        step();
        check_flag("instr_ready", instr_ready, 1'b1);
        check_flag("report_valid", report_valid, 1'b0);

        while (sent < NUM_INSTR) begin
            step();
            if (idle_left > 0) begin
                idle_left--;
                instr_valid = 1'b0;
                instr       = $urandom();
                // A bubble enters ID only when ready is high
                if (instr_ready) last_load_rd = '0;
            end else begin
                if (!have_next) begin
                    next_instr = gen_instr();
                    have_next  = 1'b1;
                end
                instr_valid = 1'b1;
                instr       = next_instr;
                if (instr_ready) begin
                    accept_instr(next_instr);
                    have_next = 1'b0;
                    sent++;
                    if ($urandom_range(0, 3) == 0) idle_left = $urandom_range(1, MAX_IDLE);
                end
            end
        end

        step();
        instr_valid = 1'b0;
        instr       = core_pkg::NOP_INSTR;
        while (expected_reports.size() > 0 || stall_pending) step();
        // Reports trail acceptance by 4 cycles, so a late extra one shows here
        repeat (6) step();

        if (reports_seen != reports_expected) begin
            other_errors++;
            $display("Saw %0d reports but the model expected %0d", reports_seen,
                     reports_expected);
        end
        print_counts();
        if (report_errors + stall_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        other_errors++;
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("Errors found");
        $finish;
    end

endmodule
